//--- src/realign_params.svh
`ifndef REALIGN_PARAMS_SVH
`define REALIGN_PARAMS_SVH

// memory and stream word width in bits
`define DATA_WIDTH 32

// byte address width
`define ADDR_WIDTH 16

// line length in bytes
`define LEN_WIDTH 8

// reads that may be in flight or buffered inside the load unit
`define LOAD_FIFO_DEPTH 2

`endif

//--- src/mem_pkg.sv
`include "realign_params.svh"

package mem_pkg;

  localparam int unsigned BYTES_PER_WORD = `DATA_WIDTH / 8;
  localparam int unsigned OFF_WIDTH      = $clog2(BYTES_PER_WORD);

  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // memory is word addressed, so the byte offset bits are dropped
  typedef logic [`ADDR_WIDTH-OFF_WIDTH-1:0] word_addr_t;

  typedef logic [OFF_WIDTH-1:0] byte_off_t;

  typedef logic [BYTES_PER_WORD-1:0] strb_t;

endpackage

//--- src/stream_pkg.sv
`include "realign_params.svh"

package stream_pkg;

  // one strobe bit per byte of a word
  localparam int unsigned STRB_WIDTH = `DATA_WIDTH / 8;

  typedef logic [`DATA_WIDTH-1:0] word_t;

  // tags that travel with every word of a line
  typedef struct packed {
    logic                  first;
    logic                  last;
    // bytes of this word that belong to the line
    logic [STRB_WIDTH-1:0] strb;
  } realign_tag_t;

endpackage

//--- src/addr_req_intf.sv
`timescale 1ns/1ps

// word read requests, address generator to load unit
interface addr_req_intf
  import mem_pkg::*, stream_pkg::*;
();

  logic         valid;
  logic         ready;
  word_addr_t   word_addr;
  realign_tag_t tag;

  modport producer (
    output valid,
    output word_addr,
    output tag,
    input  ready
  );

  modport consumer (
    input  valid,
    input  word_addr,
    input  tag,
    output ready
  );

endinterface

//--- src/load_stream_intf.sv
`timescale 1ns/1ps

// tagged words returned from memory, load unit to realigner
interface load_stream_intf
  import stream_pkg::*;
();

  logic         valid;
  logic         ready;
  word_t        data;
  // first/last flags and strobe of the read that fetched this word
  realign_tag_t tag;

  modport source (
    output valid,
    output data,
    output tag,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  tag,
    output ready
  );

endinterface

//--- src/source_addressgen.sv
`timescale 1ns/1ps
`include "realign_params.svh"

module source_addressgen
  import mem_pkg::*, stream_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  addr_t                 base_addr_i,
  input  logic [`LEN_WIDTH-1:0] len_i,
  input  logic                  busy_i,
  addr_req_intf.producer        req
);

  // byte position inside the line window, counted from the first word
  localparam int unsigned POS_W = `LEN_WIDTH + OFF_WIDTH;

  logic                  start_ok;
  logic                  active_q;
  logic [`LEN_WIDTH-1:0] cnt_q;
  logic [`LEN_WIDTH-1:0] nreads_q;
  logic [`LEN_WIDTH-1:0] nreads_d;
  logic [`LEN_WIDTH-1:0] len_q;
  word_addr_t            word_addr_q;
  byte_off_t             base_off;
  byte_off_t             off_q;
  logic [POS_W-1:0]      line_end;
  strb_t                 strb_d;
  realign_tag_t          tag_d;

  assign start_ok = start_i && !busy_i && (len_i != '0);
  assign base_off = base_addr_i[OFF_WIDTH-1:0];

  // one read per started word, plus one when the line does not start on a word
  assign nreads_d = `LEN_WIDTH'(({1'b0, len_i} + 9'd3) >> 2) + `LEN_WIDTH'(base_off != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_ok) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (req.valid && req.ready) begin
      cnt_q <= cnt_q + 1'b1;
      if (tag_d.last) begin
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      word_addr_q <= base_addr_i[`ADDR_WIDTH-1:OFF_WIDTH];
      off_q       <= base_off;
      len_q       <= len_i;
      nreads_q    <= nreads_d;
    end else if (req.valid && req.ready) begin
      word_addr_q <= word_addr_q + 1'b1;
    end
  end

  assign line_end = POS_W'(off_q) + POS_W'(len_q);

  // a byte is in the line when its window position lies in [off, off+len)
  always_comb begin
    logic [POS_W-1:0] pos;
    strb_d = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      pos       = {cnt_q, OFF_WIDTH'(i)};
      strb_d[i] = (pos >= POS_W'(off_q)) && (pos < line_end);
    end
  end

  assign tag_d.first = (cnt_q == '0);
  assign tag_d.last  = (cnt_q == nreads_q - 1'b1);
  assign tag_d.strb  = strb_d;

  assign req.valid     = active_q;
  assign req.word_addr = word_addr_q;
  assign req.tag       = tag_d;

  // a stalled request keeps its address and tags until the load unit takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req.valid && !req.ready |=> req.valid && $stable(req.word_addr) && $stable(req.tag));

endmodule

//--- src/mem_load_unit.sv
`timescale 1ns/1ps
`include "realign_params.svh"

module mem_load_unit
  import mem_pkg::*, stream_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  addr_req_intf.consumer req,
  output logic           mem_req_o,
  output word_addr_t     mem_addr_o,
  input  logic           mem_gnt_i,
  input  word_t          mem_rdata_i,
  load_stream_intf.source load
);

  localparam int unsigned DEPTH = `LOAD_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic             credit;
  logic             grant;
  logic             push;
  logic             pop;
  logic             full;
  logic             inflight_q;
  realign_tag_t     inflight_tag_q;
  word_t            fifo_data_q [DEPTH];
  realign_tag_t     fifo_tag_q  [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // outstanding read plus buffered words must leave room for one more
  assign credit = ({1'b0, count_q} + (CNT_W+1)'(inflight_q)) < (CNT_W+1)'(DEPTH);

  assign mem_req_o  = req.valid && credit;
  assign mem_addr_o = req.word_addr;
  assign grant      = mem_req_o && mem_gnt_i;
  assign req.ready  = grant;

  // rdata is valid the cycle after the grant, paired with the tag held here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= grant;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      inflight_tag_q <= req.tag;
    end
  end

  assign push = inflight_q;
  assign pop  = load.valid && load.ready;
  assign full = (count_q == CNT_W'(DEPTH));

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_data_q[wr_ptr_q] <= mem_rdata_i;
      fifo_tag_q[wr_ptr_q]  <= inflight_tag_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign load.valid = (count_q != '0);
  assign load.data  = fifo_data_q[rd_ptr_q];
  assign load.tag   = fifo_tag_q[rd_ptr_q];

  // credit check at grant time must keep room for the returning word
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> !full);

endmodule

//--- src/source_realign.sv
`timescale 1ns/1ps

module source_realign
  import mem_pkg::*, stream_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  load_stream_intf.sink load,
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output word_t        out_data_o,
  output logic         line_done_o
);

  localparam int unsigned WORD_W = $bits(word_t);
  localparam int unsigned SH_W   = $clog2(WORD_W) + 1;

  logic            line_open_q;
  word_t           prev_q;
  byte_off_t       off_q;
  byte_off_t       off_d;
  byte_off_t       cur_off;
  logic            absorb;
  logic            take;
  logic [SH_W-1:0] sh_lo;
  logic [SH_W-1:0] sh_hi;

  // rotation is the position of the lowest strobe bit of the first word
  always_comb begin
    off_d = '0;
    for (int i = STRB_WIDTH - 1; i >= 0; i--) begin
      if (load.tag.strb[i]) begin
        off_d = byte_off_t'(i);
      end
    end
  end

  assign cur_off = load.tag.first ? off_d : off_q;

  // the first word of a misaligned line only fills the previous-word register
  assign absorb = load.valid && load.tag.first && (off_d != '0);

  assign out_valid_o = load.valid && !absorb;
  assign load.ready  = absorb || out_ready_i;
  assign take        = load.valid && load.ready;

  assign sh_lo = SH_W'({cur_off, 3'b000});
  assign sh_hi = SH_W'(WORD_W) - sh_lo;

  // upper bytes of the previous word in the low lanes, then the current word
  assign out_data_o = (cur_off == '0) ? load.data :
                      (prev_q >> sh_lo) | (load.data << sh_hi);

  always_ff @(posedge clk_i) begin
    if (take) begin
      prev_q <= load.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      off_q       <= '0;
      line_open_q <= 1'b0;
    end else if (clear_i) begin
      off_q       <= '0;
      line_open_q <= 1'b0;
    end else if (take) begin
      if (load.tag.first) begin
        off_q <= off_d;
      end
      line_open_q <= !load.tag.last;
    end
  end

  // the last word is never absorbed, so this is the output handshake
  assign line_done_o = take && load.tag.last;

  // a new line may only start once the previous one saw its last word
  a_first_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    load.valid && load.tag.first |-> !line_open_q);

endmodule

//--- src/realign_source_top.sv
`timescale 1ns/1ps
`include "realign_params.svh"

module realign_source_top
  import mem_pkg::*, stream_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  addr_t                 base_addr_i,
  input  logic [`LEN_WIDTH-1:0] len_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  mem_req_o,
  output word_addr_t            mem_addr_o,
  input  logic                  mem_gnt_i,
  input  word_t                 mem_rdata_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output word_t                 out_data_o
);

  logic busy_q;
  logic done_q;
  logic start_ok;
  logic line_done;

  addr_req_intf    req_if ();
  load_stream_intf load_if ();

  // empty lines are ignored, they would never produce a last word
  assign start_ok = start_i && !busy_q && (len_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= line_done;
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (line_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

  source_addressgen addressgen_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .start_i     ( start_i     ),
    .base_addr_i ( base_addr_i ),
    .len_i       ( len_i       ),
    .busy_i      ( busy_q      ),
    .req         ( req_if      )
  );

  mem_load_unit load_unit_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req         ( req_if      ),
    .mem_req_o   ( mem_req_o   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_gnt_i   ( mem_gnt_i   ),
    .mem_rdata_i ( mem_rdata_i ),
    .load        ( load_if     )
  );

  source_realign realign_i (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .clear_i     ( start_ok    ),
    .load        ( load_if     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( out_data_o  ),
    .line_done_o ( line_done   )
  );

endmodule

//--- verification/tb_mem_model.sv
`timescale 1ns/1ps

// word-addressed memory with a stalling grant and one cycle of read latency
module tb_mem_model
  import mem_pkg::*, stream_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  word_addr_t addr_i,
  input  logic       gnt_en_i,
  output logic       gnt_o,
  output word_t      rdata_o
);

  // byte at address a holds the low 8 bits of a*7+3
  function automatic logic [7:0] mem_byte(input addr_t a);
    return 8'(a * 7 + 3);
  endfunction

  function automatic word_t mem_word(input word_addr_t w);
    word_t d;
    addr_t a;
    d = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      a           = {w, OFF_WIDTH'(i)};
      d[8*i +: 8] = mem_byte(a);
    end
    return d;
  endfunction

  assign gnt_o = req_i && gnt_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && gnt_o) begin
      rdata_o <= mem_word(addr_i);
    end
  end

endmodule

//--- verification/tb_realign_source.sv
`timescale 1ns/1ps
`include "realign_params.svh"

module tb_realign_source
  import mem_pkg::*, stream_pkg::*;
();

  localparam int GOLDEN_SIZE = 256;

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  addr_t                 base_addr;
  logic [`LEN_WIDTH-1:0] len;
  logic                  busy;
  logic                  done;
  logic                  mem_req;
  word_addr_t            mem_addr;
  logic                  mem_gnt;
  word_t                 mem_rdata;
  logic                  gnt_en;
  logic                  out_valid;
  logic                  out_ready;
  word_t                 out_data;

  logic [31:0] golden_mem [GOLDEN_SIZE];
  int          case_start [$];
  int          errors     = 0;
  int          cur_case   = 0;
  logic        loaded     = 1'b0;
  logic [31:0] lfsr_q     = 32'hcfc8_f5c3;
  logic        stall_seen = 1'b0;
  word_t       held_data;
  word_addr_t  exp_addr;

  realign_source_top dut_i (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .start_i     ( start     ),
    .base_addr_i ( base_addr ),
    .len_i       ( len       ),
    .busy_o      ( busy      ),
    .done_o      ( done      ),
    .mem_req_o   ( mem_req   ),
    .mem_addr_o  ( mem_addr  ),
    .mem_gnt_i   ( mem_gnt   ),
    .mem_rdata_i ( mem_rdata ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .out_data_o  ( out_data  )
  );

  tb_mem_model mem_i (
    .clk_i    ( clk       ),
    .rst_ni   ( rst_n     ),
    .req_i    ( mem_req   ),
    .addr_i   ( mem_addr  ),
    .gnt_en_i ( gnt_en    ),
    .gnt_o    ( mem_gnt   ),
    .rdata_o  ( mem_rdata )
  );

  // fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // random grant stalls and output back-pressure, one LFSR step per bit
  initial begin
    forever begin
      @(posedge clk);
      #10;
      lfsr_q    = lfsr_step(lfsr_q);
      gnt_en    = lfsr_q[0];
      lfsr_q    = lfsr_step(lfsr_q);
      out_ready = lfsr_q[0];
    end
  end

  // a stalled output word must hold until the sink takes it
  initial begin
    forever begin
      @(negedge clk);
      if (stall_seen) begin
        assert (out_valid && out_data == held_data) else
          log_error($sformatf("case %0d: output word changed while stalled", cur_case));
      end
      stall_seen = out_valid && !out_ready;
      held_data  = out_data;
    end
  end

  // granted reads walk the consecutive words of the line from its base word
  initial begin
    forever begin
      @(negedge clk);
      if (mem_req && mem_gnt) begin
        assert (mem_addr == exp_addr) else
          log_error($sformatf("case %0d: read of word %h, expected word %h",
                              cur_case, mem_addr, exp_addr));
        exp_addr = exp_addr + 1'b1;
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (200 * case_start.size() + 10) @(posedge clk);
    $display("timeout: the DUT did not finish all lines in time");
    $display("test failed");
    $finish;
  end

  task automatic run_line(input int c);
    int                    pos;
    int                    n;
    int                    got;
    addr_t                 base;
    logic [`LEN_WIDTH-1:0] line_len;
    pos      = case_start[c];
    base     = addr_t'(golden_mem[pos]);
    line_len = `LEN_WIDTH'(golden_mem[pos+1]);
    n        = (int'(line_len) + 3) / 4;
    cur_case = c;
    @(posedge clk);
    #10;
    exp_addr  = base[`ADDR_WIDTH-1:OFF_WIDTH];
    start     = 1'b1;
    base_addr = base;
    len       = line_len;
    fork
      begin
        @(posedge clk);
        #10;
        assert (busy) else log_error($sformatf("case %0d: busy_o did not rise", c));
        start = 1'b0;
        // command fields only count in the start cycle
        base_addr = ~base;
        len       = ~line_len;
        @(posedge clk);
        #10;
        // second command while busy, must be ignored
        start     = 1'b1;
        base_addr = base + 16'h0100;
        len       = `LEN_WIDTH'(16);
        @(posedge clk);
        #10;
        start = 1'b0;
      end
      begin
        got = 0;
        while (got < n) begin
          @(negedge clk);
          assert (!done) else log_error($sformatf("case %0d: done_o before last word", c));
          if (out_valid && out_ready) begin
            assert (out_data == golden_mem[pos+2+got]) else
              log_error($sformatf("case %0d word %0d: got %h, expected %h",
                                  c, got, out_data, golden_mem[pos+2+got]));
            got++;
          end
        end
      end
    join
    @(negedge clk);
    assert (done && !busy) else
      log_error($sformatf("case %0d: no done pulse with busy_o low after last word", c));
    @(negedge clk);
    assert (!done && !busy && !out_valid) else
      log_error($sformatf("case %0d: done_o too long or extra output after line", c));
  endtask

  initial begin
    int pos;
    rst_n     = 1'b0;
    start     = 1'b0;
    base_addr = '0;
    len       = '0;
    gnt_en    = 1'b0;
    out_ready = 1'b0;
    exp_addr  = '0;
    $readmemh("verification/realign_golden.txt", golden_mem);
    pos = 0;
    while (pos < GOLDEN_SIZE - 1 && golden_mem[pos] !== 32'hffff_ffff &&
           !$isunknown(golden_mem[pos])) begin
      case_start.push_back(pos);
      pos += 2 + (int'(golden_mem[pos+1][`LEN_WIDTH-1:0]) + 3) / 4;
    end
    if (case_start.size() == 0) begin
      errors++;
      $display("the golden file holds no test cases");
    end
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #10;
    rst_n = 1'b1;
    assert (!mem_req && !out_valid && !busy && !done) else
      log_error("outputs not low after reset");
    for (int c = 0; c < case_start.size(); c++) begin
      run_line(c);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verification/realign_golden.txt
// columns: base address, line length in bytes, then one expected output word per 4 bytes
// all fields hex, the line ffffffff ends the list
0000 20 18110a03 342d261f 5049423b 6c655e57 88817a73 a49d968f c0b9b2ab dcd5cec7
0101 13 1f18110a 3b342d26 57504942 736c655e 8f88817a
0222 0e 06fff8f1 221b140d 3e373029 5a534c45
0343 1d ede6dfd8 0902fbf4 251e1710 413a332c 5d564f48 79726b64 958e8780 b1aaa39c
1080 0c 98918a83 b4ada69f d0c9c2bb
0500 01 18110a03
0505 01 3b342d26
050a 01 5e575049
050f 01 817a736c
0610 02 88817a73
0615 02 aba49d96
061a 02 cec7c0b9
061f 02 f1eae3dc
0720 03 f8f1eae3
0725 03 1b140d06
072a 03 3e373029
072f 03 615a534c
0830 04 68615a53
0835 04 8b847d76
083a 04 aea7a099
083f 04 d1cac3bc
ffffffff

//--- flist.f
+incdir+src
src/mem_pkg.sv
src/stream_pkg.sv
src/addr_req_intf.sv
src/load_stream_intf.sv
src/source_addressgen.sv
src/mem_load_unit.sv
src/source_realign.sv
src/realign_source_top.sv
verification/tb_mem_model.sv
verification/tb_realign_source.sv

//--- Bender.yml
package:
  name: realign_source

sources:
  - include_dirs:
      - src
    files:
      - src/mem_pkg.sv
      - src/stream_pkg.sv
      - src/addr_req_intf.sv
      - src/load_stream_intf.sv
      - src/source_addressgen.sv
      - src/mem_load_unit.sv
      - src/source_realign.sv
      - src/realign_source_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_mem_model.sv
      - verification/tb_realign_source.sv
